// ==== files.f ====
+incdir+verilog
verilog/sched_pkg.sv
verilog/slot_alloc_if.sv
verilog/slot_keeper.sv
verilog/slot_pool.sv
verilog/desc_fifo.sv
verilog/desc_alloc.sv
verilog/host_regs.sv
verilog/sched_top.sv
dv/sched_asserts.sv
dv/sched_tb.sv

// ==== dv/sched_tb.sv ====
`default_nettype none
`include "sched_macros.svh"

module sched_tb;
  import sched_pkg::*;

  localparam int IFN   = `SCHED_IF_COUNT;
  localparam int CORES = `SCHED_CORE_COUNT;
  localparam int SLOTS = `SCHED_SLOT_COUNT;
  localparam int DEPTH = `SCHED_DESC_DEPTH;
  localparam int SEL   = `SCHED_HASH_SEL_OFFSET;

  logic        clk = 1'b0;
  logic        rst_r;
  logic [IFN-1:0] hash_valid;
  hash_t       hash [IFN];
  logic [IFN-1:0] hash_ready;
  logic [IFN-1:0] desc_valid;
  sched_desc_t desc [IFN];
  logic [IFN-1:0] desc_ready;
  line_count_t line_count [IFN];
  logic        slot_msg_valid;
  slot_msg_e   slot_msg_type;
  core_id_t    slot_msg_core;
  slot_t       slot_msg_slot;
  logic [31:0] host_cmd;
  logic [31:0] host_cmd_wr_data;
  logic        host_cmd_valid;
  logic [31:0] host_cmd_rd_data;

  // Reference model state
  hash_t       send_q [IFN][$];
  sched_desc_t exp_q [IFN][$];
  slot_t       free_q [CORES][$];
  logic [IFN-1:0] taken;
  int          got [IFN];
  int          drop_m [IFN];
  int          budget [CORES];
  core_mask_t  en_m;
  core_mask_t  inc_m;
  logic [31:0] lfsr_state;
  int          errors;
  int          tests;
  int          failed;
  bit          abort;

  always #2 clk = ~clk;

  sched_top dut (
    .clk             (clk),
    .rst_r           (rst_r),
    .hash_valid      (hash_valid),
    .hash            (hash),
    .hash_ready      (hash_ready),
    .desc_valid      (desc_valid),
    .desc            (desc),
    .desc_ready      (desc_ready),
    .line_count      (line_count),
    .slot_msg_valid  (slot_msg_valid),
    .slot_msg_type   (slot_msg_type),
    .slot_msg_core   (slot_msg_core),
    .slot_msg_slot   (slot_msg_slot),
    .host_cmd        (host_cmd),
    .host_cmd_wr_data(host_cmd_wr_data),
    .host_cmd_valid  (host_cmd_valid),
    .host_cmd_rd_data(host_cmd_rd_data)
  );

  bind sched_top sched_asserts u_asserts (
    .clk       (clk),
    .rst_r     (rst_r),
    .hash_valid(hash_valid),
    .hash_ready(hash_ready),
    .desc_valid(desc_valid),
    .desc      (desc),
    .desc_ready(desc_ready)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic take_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic hash_t rand_word();
    hash_t w;
    w = '0;
    for (int b = 0; b < 32; b++)
      w = {w[30:0], take_bit()};
    return w;
  endfunction

  function automatic hash_t hash_for_core(input int core);
    hash_t h;
    h = rand_word();
    h[SEL +: $bits(core_id_t)] = core_id_t'(core);
    return h;
  endfunction

  function automatic bit pipeline_idle();
    for (int i = 0; i < IFN; i++) begin
      if (send_q[i].size() != 0 || exp_q[i].size() != 0 || taken[i])
        return 1'b0;
    end
    return 1'b1;
  endfunction

  // Descriptors move at the coming rising edge, with ready as the caller left it
  task automatic tick();
    sched_desc_t e;
    sched_desc_t d;
    core_id_t    c;
    for (int i = 0; i < IFN; i++) begin
      if (desc_valid[i] && desc_ready[i]) begin
        d = desc[i];
        if (exp_q[i].size() == 0) begin
          $display("Unexpected descriptor on interface %0d at time %0t", i, $time);
          errors++;
        end else begin
          e = exp_q[i].pop_front();
          got[i]++;
          assert (d.drop == e.drop && d.hash == e.hash && d.core == e.core &&
                  (e.drop || d.slot == e.slot))
            else begin
              $display("[ERROR] %0t: if %0d desc drop %0b hash %h core %0d slot %0d",
                       $time, i, d.drop, d.hash, d.core, d.slot);
              $display("[ERROR] %0t: expected drop %0b hash %h core %0d slot %0d",
                       $time, e.drop, e.hash, e.core, e.slot);
              errors++;
            end
        end
      end
    end
    @(negedge clk);
    for (int i = 0; i < IFN; i++) begin
      if (taken[i]) begin
        taken[i] = 1'b0;
        send_q[i].delete(0);
      end else if (hash_valid[i] && hash_ready[i]) begin
        // Accepted at the coming edge, so predict the descriptor now
        e.hash = send_q[i][0];
        c      = e.hash[SEL +: $bits(core_id_t)];
        e.core = c;
        if (inc_m[c] && free_q[c].size() > 0) begin
          e.drop = 1'b0;
          e.slot = free_q[c].pop_front();
        end else begin
          e.drop = 1'b1;
          e.slot = '0;
          drop_m[i]++;
        end
        exp_q[i].push_back(e);
        taken[i] = 1'b1;
      end
      hash_valid[i] = (send_q[i].size() > 0);
      hash[i]       = hash_valid[i] ? send_q[i][0] : '0;
      assert (exp_q[i].size() <= DEPTH)
        else begin
          $display("[ERROR] %0t: %0d descriptors queued on interface %0d",
                   $time, exp_q[i].size(), i);
          errors++;
        end
    end
  endtask

  task automatic settle(input int n);
    repeat (n) tick();
  endtask

  task automatic report_timeout(input string what, input int limit);
    $display("Timeout: waiting for %s gave up after %0d cycles", what, limit);
    errors++;
    abort = 1'b1;
  endtask

  task automatic wait_drained(input string what, input int limit);
    int n;
    n = 0;
    while (!abort && !pipeline_idle()) begin
      if (n >= limit)
        report_timeout(what, limit);
      else begin
        tick();
        n++;
      end
    end
  endtask

  task automatic wait_queued(input int ifc, input int count, input int limit);
    int n;
    n = 0;
    while (!abort && exp_q[ifc].size() < count) begin
      if (n >= limit)
        report_timeout("descriptors to queue up", limit);
      else begin
        tick();
        n++;
      end
    end
  endtask

  task automatic queue_hashes(input int ifc, input int n);
    hash_t h;
    int    c;
    for (int k = 0; k < n; k++) begin
      h = rand_word();
      c = int'(h[SEL +: $bits(core_id_t)]);
      // Steer away from cores whose slots are already spoken for
      if (budget[c] == 0) begin
        for (int j = 0; j < CORES; j++) begin
          if (budget[j] > 0)
            c = j;
        end
      end
      budget[c]--;
      h[SEL +: $bits(core_id_t)] = core_id_t'(c);
      send_q[ifc].push_back(h);
    end
  endtask

  task automatic host_write(input host_reg_e r, input logic [31:0] data);
    tick();
    host_cmd         = {1'b1, r[4], 1'b1, 25'd0, r[3:0]};
    host_cmd_wr_data = data;
    host_cmd_valid   = 1'b1;
    tick();
    host_cmd_valid = 1'b0;
    settle(2);
    case (r)
      REG_CORE_ENABLE: begin
        en_m  = data[CORES-1:0];
        inc_m = inc_m & en_m;
      end
      REG_CORE_INCOME: inc_m = data[CORES-1:0] & en_m;
      REG_SLOT_FLUSH: begin
        for (int c = 0; c < CORES; c++) begin
          if (data[c])
            free_q[c].delete();
        end
      end
      default: ;
    endcase
  endtask

  // Readback shows up three edges after the command
  task automatic read_expect(input string what, input logic [4:0] r, input int idx,
                             input logic [31:0] exp);
    tick();
    host_cmd       = {1'b0, r[4], 1'b1, 21'd0, 4'(idx), r[3:0]};
    host_cmd_valid = 1'b0;
    settle(4);
    assert (host_cmd_rd_data == exp)
      else begin
        $display("[ERROR] %0t: %s %0d read %h, expected %h",
                 $time, what, idx, host_cmd_rd_data, exp);
        errors++;
      end
  endtask

  task automatic slot_message(input slot_msg_e kind, input int core, input int value);
    tick();
    slot_msg_valid = 1'b1;
    slot_msg_type  = kind;
    slot_msg_core  = core_id_t'(core);
    slot_msg_slot  = slot_t'(value);
    tick();
    slot_msg_valid = 1'b0;
    if (kind == SLOT_INIT) begin
      free_q[core].delete();
      for (int s = 1; s <= value && s <= SLOTS; s++)
        free_q[core].push_back(slot_t'(s));
    end else if (free_q[core].size() < SLOTS) begin
      free_q[core].push_back(slot_t'(value));
    end
  endtask

  task automatic record_result(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      failed++;
      $display("Test %0d %s: FAILED with %0d errors", tests, name, errors - start);
    end
  endtask

  task automatic verify_reset_state();
    int start;
    start = errors;
    repeat (5) begin
      @(negedge clk);
      assert (desc_valid == '0 && hash_ready == '0)
        else begin
          $display("[ERROR] %0t: handshake outputs active in reset", $time);
          errors++;
        end
    end
    rst_r = 1'b0;
    repeat (8) begin
      tick();
      assert (desc_valid == '0 && hash_ready == '0)
        else begin
          $display("[ERROR] %0t: handshake outputs active after reset", $time);
          errors++;
        end
    end
    read_expect("enabled mask", REG_CORE_ENABLE, 0, 32'h0);
    read_expect("incoming mask", REG_CORE_INCOME, 0, 32'h0);
    read_expect("slot count", REG_SLOT_COUNT, 0, 32'h0);
    read_expect("drop count", REG_DROP_COUNT, 0, 32'h0);
    record_result("reset state", start);
  endtask

  task automatic exercise_host_regs();
    int start;
    start = errors;
    host_write(REG_CORE_ENABLE, 32'hB);
    host_write(REG_CORE_INCOME, 32'hF);
    read_expect("enabled mask", REG_CORE_ENABLE, 0, 32'(en_m));
    read_expect("incoming mask", REG_CORE_INCOME, 0, 32'(inc_m));
    read_expect("unknown register", 5'h05, 0, 32'hFEFE_FEFE);
    host_write(REG_CORE_ENABLE, 32'h3);
    read_expect("incoming mask", REG_CORE_INCOME, 0, 32'(inc_m));
    host_write(REG_CORE_ENABLE, 32'hF);
    host_write(REG_CORE_INCOME, 32'hF);
    read_expect("incoming mask", REG_CORE_INCOME, 0, 32'(inc_m));
    record_result("host config", start);
  endtask

  task automatic allocate_descriptors();
    int start;
    start = errors;
    for (int c = 0; c < CORES; c++)
      slot_message(SLOT_INIT, c, SLOTS);
    settle(6);
    for (int c = 0; c < CORES; c++) begin
      read_expect("slot count", REG_SLOT_COUNT, c, 32'(free_q[c].size()));
      budget[c] = free_q[c].size();
    end
    for (int i = 0; i < IFN; i++)
      queue_hashes(i, 5);
    wait_drained("allocation descriptors", 300);
    for (int c = 0; c < CORES; c++)
      read_expect("slot count", REG_SLOT_COUNT, c, 32'(free_q[c].size()));
    record_result("allocation", start);
  endtask

  task automatic exhaust_core_slots();
    int start;
    start = errors;
    slot_message(SLOT_INIT, 0, 0);
    settle(6);
    read_expect("drop count", REG_DROP_COUNT, 1, 32'(drop_m[1]));
    send_q[1].push_back(hash_for_core(0));
    // Below the drop limit the hash has to wait
    repeat (20) begin
      tick();
      assert (!desc_valid[1] && exp_q[1].size() == 0)
        else begin
          $display("[ERROR] %0t: hash taken with no slot below the drop limit", $time);
          errors++;
        end
    end
    line_count[1] = `SCHED_DROP_LIMIT_RESET;
    wait_drained("dropped descriptor", 50);
    line_count[1] = '0;
    read_expect("drop count", REG_DROP_COUNT, 1, 32'(drop_m[1]));
    record_result("exhaustion", start);
  endtask

  task automatic release_and_flush_slots();
    int start;
    start = errors;
    slot_message(SLOT_INIT, 2, 3);
    slot_message(SLOT_RELEASE, 2, 7);
    settle(6);
    read_expect("slot count", REG_SLOT_COUNT, 2, 32'(free_q[2].size()));
    for (int k = 0; k < 4; k++)
      send_q[0].push_back(hash_for_core(2));
    wait_drained("released slot reuse", 100);
    read_expect("slot count", REG_SLOT_COUNT, 2, 32'(free_q[2].size()));
    slot_message(SLOT_INIT, 3, 5);
    settle(6);
    read_expect("slot count", REG_SLOT_COUNT, 3, 32'(free_q[3].size()));
    host_write(REG_SLOT_FLUSH, 32'h8);
    settle(2);
    read_expect("slot count", REG_SLOT_COUNT, 3, 32'(free_q[3].size()));
    record_result("release and flush", start);
  endtask

  task automatic hold_back_pressure();
    int start;
    int got_before;
    start = errors;
    for (int c = 0; c < CORES; c++) begin
      slot_message(SLOT_INIT, c, SLOTS);
      budget[c] = SLOTS;
    end
    settle(6);
    got_before    = got[2];
    desc_ready[2] = 1'b0;
    queue_hashes(2, DEPTH + 3);
    wait_queued(2, DEPTH, 100);
    settle(10);
    assert (send_q[2].size() == 3)
      else begin
        $display("[ERROR] %0t: %0d hashes still waiting, expected 3",
                 $time, send_q[2].size());
        errors++;
      end
    desc_ready[2] = 1'b1;
    wait_drained("back-pressure drain", 200);
    assert (got[2] - got_before == DEPTH + 3)
      else begin
        $display("[ERROR] %0t: %0d descriptors received, expected %0d",
                 $time, got[2] - got_before, DEPTH + 3);
        errors++;
      end
    record_result("back-pressure", start);
  endtask

  task automatic finish_run();
    int total;
    total = errors + dut.u_asserts.fail_count;
    $display("Tests run %0d, failed %0d, errors %0d", tests, failed, total);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  initial begin
    rst_r            = 1'b1;
    hash_valid       = '0;
    desc_ready       = '1;
    slot_msg_valid   = 1'b0;
    slot_msg_type    = SLOT_RELEASE;
    slot_msg_core    = '0;
    slot_msg_slot    = '0;
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    taken            = '0;
    en_m             = '0;
    inc_m            = '0;
    lfsr_state       = 32'h0bb0_c3f2;
    errors           = 0;
    tests            = 0;
    failed           = 0;
    abort            = 1'b0;
    for (int i = 0; i < IFN; i++) begin
      hash[i]       = '0;
      line_count[i] = '0;
      got[i]        = 0;
      drop_m[i]     = 0;
    end
    verify_reset_state();
    exercise_host_regs();
    allocate_descriptors();
    exhaust_core_slots();
    release_and_flush_slots();
    hold_back_pressure();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== dv/sched_asserts.sv ====
`default_nettype none
`include "sched_macros.svh"

module sched_asserts (
  input wire                         clk,
  input wire                         rst_r,
  input wire [`SCHED_IF_COUNT-1:0]   hash_valid,
  input wire [`SCHED_IF_COUNT-1:0]   hash_ready,
  input wire [`SCHED_IF_COUNT-1:0]   desc_valid,
  input wire sched_pkg::sched_desc_t desc [`SCHED_IF_COUNT],
  input wire [`SCHED_IF_COUNT-1:0]   desc_ready
);
  int   fail_count = 0;
  logic rst_seen   = 1'b0;

  // Skips the very first edge, before the reset has been seen
  always @(posedge clk) begin
    rst_seen <= rst_r;
  end

  a_no_desc_in_reset: assert property (@(posedge clk) (rst_r && rst_seen) |-> (desc_valid == '0))
    else begin
      $error("desc_valid high during reset");
      fail_count++;
    end

  for (genvar g = 0; g < `SCHED_IF_COUNT; g++) begin : g_if
    a_desc_stable: assert property (@(posedge clk) disable iff (rst_r)
        (desc_valid[g] && !desc_ready[g]) |=> $stable(desc[g]))
      else begin
        $error("desc changed while stalled on interface %0d", g);
        fail_count++;
      end

    a_ready_needs_valid: assert property (@(posedge clk) disable iff (rst_r)
        hash_ready[g] |-> hash_valid[g])
      else begin
        $error("hash_ready without hash_valid on interface %0d", g);
        fail_count++;
      end
  end

endmodule

`default_nettype wire

// ==== verilog/sched_top.sv ====
`default_nettype none
`include "sched_macros.svh"

module sched_top (
  input  wire                         clk,
  input  wire                         rst_r,
  input  wire [`SCHED_IF_COUNT-1:0]   hash_valid,
  input  wire sched_pkg::hash_t       hash [`SCHED_IF_COUNT],
  output logic [`SCHED_IF_COUNT-1:0]  hash_ready,
  output logic [`SCHED_IF_COUNT-1:0]  desc_valid,
  output sched_pkg::sched_desc_t      desc [`SCHED_IF_COUNT],
  input  wire [`SCHED_IF_COUNT-1:0]   desc_ready,
  input  wire sched_pkg::line_count_t line_count [`SCHED_IF_COUNT],
  input  wire                         slot_msg_valid,
  input  wire sched_pkg::slot_msg_e   slot_msg_type,
  input  wire sched_pkg::core_id_t    slot_msg_core,
  input  wire sched_pkg::slot_t       slot_msg_slot,
  input  wire [31:0]                  host_cmd,
  input  wire [31:0]                  host_cmd_wr_data,
  input  wire                         host_cmd_valid,
  output logic [31:0]                 host_cmd_rd_data
);
  import sched_pkg::*;

  core_mask_t                 enabled_cores;
  core_mask_t                 income_cores;
  core_mask_t                 slot_flush;
  logic [`SCHED_IF_COUNT-1:0] almost_full;
  slot_t                      slot_count [`SCHED_CORE_COUNT];
  logic                       drop_event;
  if_id_t                     drop_if;

  slot_alloc_if alloc_if ();

  host_regs u_host_regs (
    .clk             (clk),
    .rst_r           (rst_r),
    .host_cmd        (host_cmd),
    .host_cmd_wr_data(host_cmd_wr_data),
    .host_cmd_valid  (host_cmd_valid),
    .host_cmd_rd_data(host_cmd_rd_data),
    .line_count      (line_count),
    .slot_count      (slot_count),
    .drop_event      (drop_event),
    .drop_if         (drop_if),
    .enabled_cores   (enabled_cores),
    .income_cores    (income_cores),
    .slot_flush      (slot_flush),
    .almost_full     (almost_full)
  );

  slot_pool u_slot_pool (
    .clk           (clk),
    .rst_r         (rst_r),
    .slot_msg_valid(slot_msg_valid),
    .slot_msg_type (slot_msg_type),
    .slot_msg_core (slot_msg_core),
    .slot_msg_slot (slot_msg_slot),
    .slot_flush    (slot_flush),
    .enabled_cores (enabled_cores),
    .slot_count    (slot_count),
    .alloc         (alloc_if.pool)
  );

  desc_alloc u_desc_alloc (
    .clk         (clk),
    .rst_r       (rst_r),
    .hash_valid  (hash_valid),
    .hash        (hash),
    .hash_ready  (hash_ready),
    .desc_valid  (desc_valid),
    .desc        (desc),
    .desc_ready  (desc_ready),
    .income_cores(income_cores),
    .almost_full (almost_full),
    .drop_event  (drop_event),
    .drop_if     (drop_if),
    .alloc       (alloc_if.alloc)
  );

endmodule

`default_nettype wire

// ==== verilog/host_regs.sv ====
`default_nettype none
`include "sched_macros.svh"

module host_regs (
  input  wire                         clk,
  input  wire                         rst_r,
  input  wire [31:0]                  host_cmd,
  input  wire [31:0]                  host_cmd_wr_data,
  input  wire                         host_cmd_valid,
  output logic [31:0]                 host_cmd_rd_data,
  input  wire sched_pkg::line_count_t line_count [`SCHED_IF_COUNT],
  input  wire sched_pkg::slot_t       slot_count [`SCHED_CORE_COUNT],
  input  wire                         drop_event,
  input  wire sched_pkg::if_id_t      drop_if,
  output sched_pkg::core_mask_t       enabled_cores,
  output sched_pkg::core_mask_t       income_cores,
  output sched_pkg::core_mask_t       slot_flush,
  output logic [`SCHED_IF_COUNT-1:0]  almost_full
);
  import sched_pkg::*;

  logic [31:0] wr_data_r;
  logic        wr_r;
  logic        to_if_r;
  logic [3:0]  reg_r;
  core_id_t    rd_core_r;
  if_id_t      rd_if_r;
  host_reg_e   reg_sel;
  core_mask_t  wr_mask;
  logic [31:0] rd_data_n;
  line_count_t line_count_r [`SCHED_IF_COUNT];
  line_count_t drop_limit;
  logic [31:0] drop_count [`SCHED_IF_COUNT];

  // Command stage, a write needs bit 31 and the scheduler target bit 29
  always_ff @(posedge clk) begin
    wr_data_r <= host_cmd_wr_data;
    to_if_r   <= host_cmd[30];
    reg_r     <= host_cmd[3:0];
    rd_core_r <= host_cmd[4 +: $bits(core_id_t)];
    rd_if_r   <= host_cmd[4 +: $bits(if_id_t)];
    if (rst_r)
      wr_r <= 1'b0;
    else
      wr_r <= host_cmd_valid && host_cmd[31] && host_cmd[29];
  end

  assign reg_sel = host_reg_e'({to_if_r, reg_r});
  assign wr_mask = wr_data_r[$bits(core_mask_t)-1:0];

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slot_flush    <= '0;
      drop_limit    <= `SCHED_DROP_LIMIT_RESET;
    end else begin
      // Flush is a one-cycle strobe
      slot_flush <= '0;
      if (wr_r) begin
        case (reg_sel)
          REG_CORE_ENABLE: begin
            // Disabled cores lose their incoming bit too
            enabled_cores <= wr_mask;
            income_cores  <= income_cores & wr_mask;
          end
          REG_CORE_INCOME: income_cores <= wr_mask & enabled_cores;
          REG_SLOT_FLUSH:  slot_flush   <= wr_mask;
          REG_DROP_LIMIT:  drop_limit   <= wr_data_r[`SCHED_LINE_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // Backlog is registered first, then compared
  always_ff @(posedge clk) begin
    line_count_r <= line_count;
    if (rst_r) begin
      almost_full <= '0;
    end else begin
      for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
        almost_full[i] <= (line_count_r[i] >= drop_limit);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
        drop_count[i] <= '0;
      end
    end else if (drop_event) begin
      drop_count[drop_if] <= drop_count[drop_if] + 32'd1;
    end
  end

  // Two readback stages after the command stage
  always_ff @(posedge clk) begin
    case (reg_sel)
      REG_CORE_ENABLE: rd_data_n <= 32'(enabled_cores);
      REG_CORE_INCOME: rd_data_n <= 32'(income_cores);
      REG_SLOT_COUNT:  rd_data_n <= 32'(slot_count[rd_core_r]);
      REG_DROP_LIMIT:  rd_data_n <= 32'(drop_limit);
      REG_DROP_COUNT: begin
        if (int'(rd_if_r) < `SCHED_IF_COUNT)
          rd_data_n <= drop_count[rd_if_r];
        else
          rd_data_n <= `SCHED_RD_DEFAULT;
      end
      default:         rd_data_n <= `SCHED_RD_DEFAULT;
    endcase
    host_cmd_rd_data <= rd_data_n;
  end

endmodule

`default_nettype wire

// ==== verilog/desc_alloc.sv ====
`default_nettype none
`include "sched_macros.svh"

module desc_alloc (
  input  wire                         clk,
  input  wire                         rst_r,
  input  wire [`SCHED_IF_COUNT-1:0]   hash_valid,
  input  wire sched_pkg::hash_t       hash [`SCHED_IF_COUNT],
  output logic [`SCHED_IF_COUNT-1:0]  hash_ready,
  output logic [`SCHED_IF_COUNT-1:0]  desc_valid,
  output sched_pkg::sched_desc_t      desc [`SCHED_IF_COUNT],
  input  wire [`SCHED_IF_COUNT-1:0]   desc_ready,
  input  wire sched_pkg::core_mask_t  income_cores,
  input  wire [`SCHED_IF_COUNT-1:0]   almost_full,
  output logic                        drop_event,
  output sched_pkg::if_id_t           drop_if,
  slot_alloc_if.alloc                 alloc
);
  import sched_pkg::*;

  logic [`SCHED_IF_COUNT-1:0] fifo_ready;
  logic [`SCHED_IF_COUNT-1:0] req;
  logic [`SCHED_IF_COUNT-1:0] grant_oh_r;
  logic                       grant_v;
  if_id_t                     grant_idx;
  if_id_t                     last_grant;
  logic                       grant_v_r;
  if_id_t                     grant_idx_r;
  core_id_t                   dest_core_r;
  logic                       active;
  logic                       slot_ok;
  logic                       accept;
  sched_desc_t                wr_desc;

  // Last cycle's grant is still being resolved, so skip it
  assign req = hash_valid & fifo_ready & ~grant_oh_r;

  // Round robin, search starts just after the last winner
  always_comb begin
    int cand;
    grant_v   = 1'b0;
    grant_idx = last_grant;
    for (int k = 1; k <= `SCHED_IF_COUNT; k++) begin
      cand = (int'(last_grant) + k) % `SCHED_IF_COUNT;
      if (!grant_v && req[cand]) begin
        grant_v   = 1'b1;
        grant_idx = if_id_t'(cand);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_v_r   <= 1'b0;
      grant_idx_r <= '0;
      grant_oh_r  <= '0;
      last_grant  <= if_id_t'(`SCHED_IF_COUNT - 1);
    end else begin
      grant_v_r   <= grant_v;
      grant_idx_r <= grant_idx;
      grant_oh_r  <= '0;
      if (grant_v) begin
        grant_oh_r[grant_idx] <= 1'b1;
        last_grant            <= grant_idx;
      end
    end
  end

  // Destination core comes from the low hash bits of the winner
  always_ff @(posedge clk) begin
    dest_core_r <= hash[grant_idx][`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)];
  end

  // Second cycle: allocate, drop on backlog, or leave the hash waiting
  assign active  = grant_v_r && hash_valid[grant_idx_r];
  assign slot_ok = alloc.slot_valid[dest_core_r] && income_cores[dest_core_r];
  assign accept  = active && (slot_ok || almost_full[grant_idx_r]);

  assign alloc.pop      = active && slot_ok;
  assign alloc.pop_core = dest_core_r;
  assign drop_event     = accept && !slot_ok;
  assign drop_if        = grant_idx_r;

  always_comb begin
    hash_ready = '0;
    if (accept)
      hash_ready[grant_idx_r] = 1'b1;
    wr_desc.drop = !slot_ok;
    wr_desc.hash = hash[grant_idx_r];
    wr_desc.core = dest_core_r;
    wr_desc.slot = slot_ok ? alloc.head_slot[dest_core_r] : '0;
  end

  for (genvar g = 0; g < `SCHED_IF_COUNT; g++) begin : g_if
    desc_fifo u_fifo (
      .clk      (clk),
      .rst_r    (rst_r),
      .in_valid (hash_ready[g]),
      .in_desc  (wr_desc),
      .in_ready (fifo_ready[g]),
      .out_valid(desc_valid[g]),
      .out_desc (desc[g]),
      .out_ready(desc_ready[g])
    );
  end

endmodule

`default_nettype wire

// ==== verilog/desc_fifo.sv ====
`default_nettype none
`include "sched_macros.svh"

module desc_fifo (
  input  wire                         clk,
  input  wire                         rst_r,
  input  wire                         in_valid,
  input  wire sched_pkg::sched_desc_t in_desc,
  output logic                        in_ready,
  output logic                        out_valid,
  output sched_pkg::sched_desc_t      out_desc,
  input  wire                         out_ready
);
  import sched_pkg::*;

  localparam int               PTR_W = $clog2(`SCHED_DESC_DEPTH);
  localparam logic [PTR_W:0]   FULL  = `SCHED_DESC_DEPTH;

  sched_desc_t      mem [`SCHED_DESC_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != FULL);
  assign out_valid = (count != '0);
  assign out_desc  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_desc;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/slot_pool.sv ====
`default_nettype none
`include "sched_macros.svh"

module slot_pool (
  input  wire                        clk,
  input  wire                        rst_r,
  input  wire                        slot_msg_valid,
  input  wire sched_pkg::slot_msg_e  slot_msg_type,
  input  wire sched_pkg::core_id_t   slot_msg_core,
  input  wire sched_pkg::slot_t      slot_msg_slot,
  input  wire sched_pkg::core_mask_t slot_flush,
  input  wire sched_pkg::core_mask_t enabled_cores,
  output sched_pkg::slot_t           slot_count [`SCHED_CORE_COUNT],
  slot_alloc_if.pool                 alloc
);
  import sched_pkg::*;

  core_mask_t init_v;
  core_mask_t release_v;
  slot_t      msg_slot_r;
  core_mask_t keeper_valid;

  // Decode the message into per-core strobes, one cycle late
  always_ff @(posedge clk) begin
    msg_slot_r <= slot_msg_slot;
    if (rst_r) begin
      init_v    <= '0;
      release_v <= '0;
    end else begin
      for (int i = 0; i < `SCHED_CORE_COUNT; i++) begin
        init_v[i]    <= slot_msg_valid && (slot_msg_type == SLOT_INIT) &&
                        (slot_msg_core == core_id_t'(i));
        release_v[i] <= slot_msg_valid && (slot_msg_type == SLOT_RELEASE) &&
                        (slot_msg_core == core_id_t'(i));
      end
    end
  end

  for (genvar g = 0; g < `SCHED_CORE_COUNT; g++) begin : g_core
    slot_keeper u_keeper (
      .clk          (clk),
      .rst_r        (rst_r),
      .flush        (slot_flush[g]),
      .init_valid   (init_v[g]),
      .init_count   (msg_slot_r),
      .release_valid(release_v[g]),
      .release_slot (msg_slot_r),
      .pop          (alloc.pop && (alloc.pop_core == core_id_t'(g))),
      .head_slot    (alloc.head_slot[g]),
      .slot_valid   (keeper_valid[g]),
      .slot_count   (slot_count[g])
    );
  end

  // A disabled core never offers a slot
  assign alloc.slot_valid = keeper_valid & enabled_cores;

endmodule

`default_nettype wire

// ==== verilog/slot_keeper.sv ====
`default_nettype none
`include "sched_macros.svh"

module slot_keeper (
  input  wire                     clk,
  input  wire                     rst_r,
  input  wire                     flush,
  input  wire                     init_valid,
  input  wire sched_pkg::slot_t   init_count,
  input  wire                     release_valid,
  input  wire sched_pkg::slot_t   release_slot,
  input  wire                     pop,
  output sched_pkg::slot_t        head_slot,
  output logic                    slot_valid,
  output sched_pkg::slot_t        slot_count
);
  import sched_pkg::*;

  localparam int PTR_W = $clog2(`SCHED_SLOT_COUNT);

  slot_t            mem [`SCHED_SLOT_COUNT];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  slot_t            count;
  slot_t            init_len;
  logic             do_push;
  logic             do_pop;

  // Init cannot ask for more slots than the FIFO holds
  assign init_len = (init_count > slot_t'(`SCHED_SLOT_COUNT)) ?
                    slot_t'(`SCHED_SLOT_COUNT) : init_count;
  assign do_pop   = pop && (count != '0);
  assign do_push  = release_valid && (count != slot_t'(`SCHED_SLOT_COUNT));

  assign head_slot  = mem[rd_ptr];
  assign slot_valid = (count != '0);
  assign slot_count = count;

  // Init fills the whole ring with slots 1 and up
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (do_push) begin
      mem[wr_ptr] <= release_slot;
    end
  end

  // Pointers wrap naturally with a power-of-two pool
  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= init_len[PTR_W-1:0];
      count  <= init_len;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/slot_alloc_if.sv ====
`default_nettype none
`include "sched_macros.svh"

interface slot_alloc_if;
  import sched_pkg::*;

  // Per-core head of the free slot FIFOs
  core_mask_t slot_valid;
  slot_t      head_slot [`SCHED_CORE_COUNT];

  // Pop request, applied at the next edge
  logic       pop;
  core_id_t   pop_core;

  modport pool (output slot_valid, output head_slot, input pop, input pop_core);
  modport alloc (input slot_valid, input head_slot, output pop, output pop_core);

endinterface

`default_nettype wire

// ==== verilog/sched_pkg.sv ====
`default_nettype none
`include "sched_macros.svh"

package sched_pkg;

  typedef logic [31:0]                            hash_t;
  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0]   core_id_t;
  // One value more than the pool size so a full count fits
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;
  typedef logic [$clog2(`SCHED_IF_COUNT)-1:0]     if_id_t;
  typedef logic [`SCHED_LINE_WIDTH-1:0]           line_count_t;
  typedef logic [`SCHED_CORE_COUNT-1:0]           core_mask_t;

  typedef struct packed {
    logic     drop;
    hash_t    hash;
    core_id_t core;
    slot_t    slot;
  } sched_desc_t;

  typedef enum logic {
    SLOT_RELEASE = 1'b0,
    SLOT_INIT    = 1'b1
  } slot_msg_e;

  // Interface-not-core flag on top of the register number
  typedef enum logic [4:0] {
    REG_CORE_ENABLE = 5'h00,
    REG_CORE_INCOME = 5'h01,
    REG_SLOT_FLUSH  = 5'h02,
    REG_SLOT_COUNT  = 5'h03,
    REG_DROP_COUNT  = 5'h12,
    REG_DROP_LIMIT  = 5'h13
  } host_reg_e;

endpackage

`default_nettype wire

// ==== verilog/sched_macros.svh ====
`ifndef SCHED_MACROS_SVH
`define SCHED_MACROS_SVH

// Scheduler sizing
`define SCHED_IF_COUNT        3
`define SCHED_CORE_COUNT      4
`define SCHED_SLOT_COUNT      8
`define SCHED_LINE_WIDTH      13
`define SCHED_DESC_DEPTH      4

// Core select field starts here in the flow hash
`define SCHED_HASH_SEL_OFFSET 0

// Reset and readback values
`define SCHED_DROP_LIMIT_RESET {4'd7, {(`SCHED_LINE_WIDTH-4){1'b0}}}
`define SCHED_RD_DEFAULT       32'hFEFE_FEFE

`endif
